// File: hw/miss_pkg.sv
package miss_pkg;

    // physical address and data widths
    localparam int paddr_width = 32;
    localparam int word_bits = 64;

    // a line holds 4 words of 8 bytes
    localparam int line_words = 4;
    localparam int line_offset_width = 5;
    localparam int word_sel_width = 2;
    localparam int word_offset_width = line_offset_width - word_sel_width;
    localparam int line_addr_width = paddr_width - line_offset_width;

    localparam int lq_idx_width = 5;

    typedef logic [line_addr_width-1:0] line_addr_t;
    typedef logic [word_bits-1:0] word_t;
    // word 0 sits in the low bits
    typedef logic [line_words-1:0][word_bits-1:0] line_t;

    // read-address channel states
    typedef enum logic {
        fetch_idle,
        fetch_req
    } fetch_state_t;

endpackage

// File: hw/miss_table.sv
`timescale 1ns/1ps

module miss_table #(
    parameter int load_ports = 2,
    parameter int miss_entries = 4,
    localparam int entry_bits = $clog2(miss_entries)
) (
    input  logic clk,
    input  logic rst,
    input  logic [load_ports-1:0] ld_valid,
    input  logic [load_ports-1:0][miss_pkg::paddr_width-1:0] ld_addr,
    input  logic [load_ports-1:0] slot_free,
    input  logic [miss_entries-1:0] entry_waiting,
    input  logic fetch_issue,
    input  logic [entry_bits-1:0] fetch_entry,
    input  logic line_done,
    input  logic [entry_bits-1:0] done_entry,
    input  miss_pkg::line_t done_line,
    input  logic refill_ready,
    output logic [load_ports-1:0] ld_full,
    output logic [load_ports-1:0] alloc_valid,
    output logic [load_ports-1:0][entry_bits-1:0] alloc_entry,
    output logic [load_ports-1:0][miss_pkg::word_sel_width-1:0] alloc_word,
    output logic [miss_entries-1:0] fetch_pending,
    output miss_pkg::line_addr_t [miss_entries-1:0] entry_addr,
    output logic [miss_entries-1:0] line_ready,
    output miss_pkg::line_t [miss_entries-1:0] entry_data,
    output logic refill_valid,
    output logic [miss_pkg::paddr_width-1:0] refill_addr,
    output miss_pkg::line_t refill_data
);

    logic [miss_entries-1:0] entry_valid;
    logic [miss_entries-1:0] refilled;
    logic [miss_entries-1:0] merge_hit;
    logic [miss_entries-1:0] retire;
    logic [load_ports-1:0] new_alloc;
    miss_pkg::line_addr_t [load_ports-1:0] ld_line;

    logic refill_busy;
    logic [entry_bits-1:0] refill_sel;
    logic [entry_bits-1:0] refill_pick;
    logic refill_found;

    always_comb begin
        for (int i = 0; i < load_ports; i++) begin
            ld_line[i] = ld_addr[i][miss_pkg::paddr_width-1:miss_pkg::line_offset_width];
            alloc_word[i] = ld_addr[i][miss_pkg::word_offset_width +: miss_pkg::word_sel_width];
        end
    end

    // match, same-cycle merge, then free entry in port order
    always_comb begin
        logic [miss_entries-1:0] taken;
        logic hit;
        logic same;
        logic found;
        logic [entry_bits-1:0] idx;
        taken = '0;
        new_alloc = '0;
        alloc_valid = '0;
        alloc_entry = '0;
        for (int i = 0; i < load_ports; i++) begin
            hit = 1'b0;
            same = 1'b0;
            found = 1'b0;
            idx = '0;
            for (int j = miss_entries - 1; j >= 0; j--) begin
                if (entry_valid[j] && entry_addr[j] == ld_line[i]) begin
                    hit = 1'b1;
                    idx = entry_bits'(j);
                end
            end
            // lower port already opened this line
            for (int k = 0; k < i; k++) begin
                if (!hit && !same && new_alloc[k] && ld_line[k] == ld_line[i]) begin
                    same = 1'b1;
                    idx = alloc_entry[k];
                end
            end
            if (!hit && !same) begin
                for (int j = miss_entries - 1; j >= 0; j--) begin
                    if (!entry_valid[j] && !taken[j]) begin
                        found = 1'b1;
                        idx = entry_bits'(j);
                    end
                end
            end
            alloc_valid[i] = ld_valid[i] && slot_free[i] && (hit || same || found);
            alloc_entry[i] = idx;
            if (alloc_valid[i] && !hit && !same) begin
                new_alloc[i] = 1'b1;
                taken[idx] = 1'b1;
            end
        end
    end

    // a load merging this cycle keeps its entry alive
    always_comb begin
        merge_hit = '0;
        for (int i = 0; i < load_ports; i++) begin
            if (alloc_valid[i]) begin
                merge_hit[alloc_entry[i]] = 1'b1;
            end
        end
    end

    assign retire = entry_valid & line_ready & refilled & ~entry_waiting & ~merge_hit;

    always_comb begin
        refill_found = 1'b0;
        refill_pick = '0;
        for (int j = miss_entries - 1; j >= 0; j--) begin
            if (entry_valid[j] && line_ready[j] && !refilled[j]) begin
                refill_found = 1'b1;
                refill_pick = entry_bits'(j);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ld_full <= '0;
            entry_valid <= '0;
            fetch_pending <= '0;
            line_ready <= '0;
            refilled <= '0;
            refill_busy <= 1'b0;
            refill_sel <= '0;
        end else begin
            ld_full <= ld_valid & ~alloc_valid;
            for (int i = 0; i < load_ports; i++) begin
                if (new_alloc[i]) begin
                    entry_valid[alloc_entry[i]] <= 1'b1;
                    fetch_pending[alloc_entry[i]] <= 1'b1;
                    line_ready[alloc_entry[i]] <= 1'b0;
                    refilled[alloc_entry[i]] <= 1'b0;
                end
            end
            if (fetch_issue) begin
                fetch_pending[fetch_entry] <= 1'b0;
            end
            if (line_done) begin
                line_ready[done_entry] <= 1'b1;
            end
            // refill choice is locked until the cache takes it
            if (refill_busy) begin
                if (refill_ready) begin
                    refilled[refill_sel] <= 1'b1;
                    refill_busy <= 1'b0;
                end
            end else if (refill_found) begin
                refill_busy <= 1'b1;
                refill_sel <= refill_pick;
            end
            for (int j = 0; j < miss_entries; j++) begin
                if (retire[j]) begin
                    entry_valid[j] <= 1'b0;
                    line_ready[j] <= 1'b0;
                    refilled[j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < load_ports; i++) begin
            if (new_alloc[i]) begin
                entry_addr[alloc_entry[i]] <= ld_line[i];
            end
        end
        if (line_done) begin
            entry_data[done_entry] <= done_line;
        end
    end

    assign refill_valid = refill_busy;
    assign refill_addr = {entry_addr[refill_sel], {miss_pkg::line_offset_width{1'b0}}};
    assign refill_data = entry_data[refill_sel];

endmodule

// File: hw/miss_fetch.sv
`timescale 1ns/1ps

module miss_fetch #(
    parameter int miss_entries = 4,
    parameter int id_count = 2,
    localparam int entry_bits = $clog2(miss_entries),
    localparam int id_bits = $clog2(id_count)
) (
    input  logic clk,
    input  logic rst,
    input  logic [miss_entries-1:0] fetch_pending,
    input  miss_pkg::line_addr_t [miss_entries-1:0] entry_addr,
    input  logic ar_ready,
    input  logic r_valid,
    input  logic [id_bits-1:0] r_id,
    input  miss_pkg::word_t r_data,
    input  logic r_last,
    output logic ar_valid,
    output logic [miss_pkg::paddr_width-1:0] ar_addr,
    output logic [id_bits-1:0] ar_id,
    output logic fetch_issue,
    output logic [entry_bits-1:0] fetch_entry,
    output logic line_done,
    output logic [entry_bits-1:0] done_entry,
    output miss_pkg::line_t done_line
);

    miss_pkg::fetch_state_t state;

    logic [id_count-1:0] id_busy;
    logic [entry_bits-1:0] id_map [id_count];
    logic [miss_pkg::word_sel_width-1:0] beat_cnt [id_count];
    miss_pkg::line_t line_buf [id_count];

    logic [entry_bits-1:0] pend_idx;
    logic pend_any;
    logic [id_bits-1:0] free_id;
    logic free_any;
    logic [entry_bits-1:0] req_entry;
    logic [id_bits-1:0] done_id;

    // lowest pending entry and lowest free id
    always_comb begin
        pend_any = 1'b0;
        pend_idx = '0;
        for (int j = miss_entries - 1; j >= 0; j--) begin
            if (fetch_pending[j]) begin
                pend_any = 1'b1;
                pend_idx = entry_bits'(j);
            end
        end
        free_any = 1'b0;
        free_id = '0;
        for (int k = id_count - 1; k >= 0; k--) begin
            if (!id_busy[k]) begin
                free_any = 1'b1;
                free_id = id_bits'(k);
            end
        end
    end

    assign ar_valid = (state == miss_pkg::fetch_req);
    assign fetch_issue = ar_valid && ar_ready;
    assign fetch_entry = req_entry;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= miss_pkg::fetch_idle;
            id_busy <= '0;
            line_done <= 1'b0;
            for (int k = 0; k < id_count; k++) begin
                beat_cnt[k] <= '0;
            end
        end else begin
            case (state)
                miss_pkg::fetch_idle: begin
                    if (pend_any && free_any) begin
                        id_busy[free_id] <= 1'b1;
                        state <= miss_pkg::fetch_req;
                    end
                end
                miss_pkg::fetch_req: begin
                    if (ar_ready) begin
                        state <= miss_pkg::fetch_idle;
                    end
                end
                default: state <= miss_pkg::fetch_idle;
            endcase
            if (r_valid) begin
                beat_cnt[r_id] <= beat_cnt[r_id] + 1'b1;
            end
            // id free again once its burst ends
            if (r_valid && r_last) begin
                id_busy[r_id] <= 1'b0;
            end
            line_done <= r_valid && r_last;
        end
    end

    always_ff @(posedge clk) begin
        if (state == miss_pkg::fetch_idle && pend_any && free_any) begin
            ar_addr <= {entry_addr[pend_idx], {miss_pkg::line_offset_width{1'b0}}};
            ar_id <= free_id;
            req_entry <= pend_idx;
            id_map[free_id] <= pend_idx;
        end
        if (r_valid) begin
            line_buf[r_id][beat_cnt[r_id]] <= r_data;
        end
        done_entry <= id_map[r_id];
        done_id <= r_id;
    end

    // last beat lands in the buffer on the same edge
    assign done_line = line_buf[done_id];

endmodule

// File: hw/miss_wakeup.sv
`timescale 1ns/1ps

module miss_wakeup #(
    parameter int load_ports = 2,
    parameter int miss_entries = 4,
    parameter int wait_slots = 4,
    localparam int entry_bits = $clog2(miss_entries),
    localparam int slot_bits = $clog2(wait_slots)
) (
    input  logic clk,
    input  logic rst,
    input  logic [load_ports-1:0] alloc_valid,
    input  logic [load_ports-1:0][entry_bits-1:0] alloc_entry,
    input  logic [load_ports-1:0][miss_pkg::word_sel_width-1:0] alloc_word,
    input  logic [load_ports-1:0][miss_pkg::lq_idx_width-1:0] ld_lq_idx,
    input  logic [miss_entries-1:0] line_ready,
    input  miss_pkg::line_t [miss_entries-1:0] entry_data,
    output logic [load_ports-1:0] slot_free,
    output logic [miss_entries-1:0] entry_waiting,
    output logic [load_ports-1:0] wake_valid,
    output logic [load_ports-1:0][miss_pkg::lq_idx_width-1:0] wake_lq_idx,
    output miss_pkg::word_t [load_ports-1:0] wake_data
);

    logic [wait_slots-1:0] slot_used [load_ports];
    logic [entry_bits-1:0] slot_entry [load_ports][wait_slots];
    logic [miss_pkg::word_sel_width-1:0] slot_word [load_ports][wait_slots];
    logic [miss_pkg::lq_idx_width-1:0] slot_lq [load_ports][wait_slots];

    logic [slot_bits-1:0] free_idx [load_ports];
    logic [slot_bits-1:0] wake_idx [load_ports];
    logic [load_ports-1:0] wake_hit;

    // lowest free slot and lowest ready slot of each port
    always_comb begin
        for (int i = 0; i < load_ports; i++) begin
            slot_free[i] = 1'b0;
            free_idx[i] = '0;
            wake_hit[i] = 1'b0;
            wake_idx[i] = '0;
            for (int s = wait_slots - 1; s >= 0; s--) begin
                if (!slot_used[i][s]) begin
                    slot_free[i] = 1'b1;
                    free_idx[i] = slot_bits'(s);
                end
                if (slot_used[i][s] && line_ready[slot_entry[i][s]]) begin
                    wake_hit[i] = 1'b1;
                    wake_idx[i] = slot_bits'(s);
                end
            end
        end
    end

    always_comb begin
        entry_waiting = '0;
        for (int i = 0; i < load_ports; i++) begin
            for (int s = 0; s < wait_slots; s++) begin
                if (slot_used[i][s]) begin
                    entry_waiting[slot_entry[i][s]] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wake_valid <= '0;
            for (int i = 0; i < load_ports; i++) begin
                slot_used[i] <= '0;
            end
        end else begin
            wake_valid <= wake_hit;
            for (int i = 0; i < load_ports; i++) begin
                // free slot and woken slot never coincide
                if (alloc_valid[i]) begin
                    slot_used[i][free_idx[i]] <= 1'b1;
                end
                if (wake_hit[i]) begin
                    slot_used[i][wake_idx[i]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < load_ports; i++) begin
            if (alloc_valid[i]) begin
                slot_entry[i][free_idx[i]] <= alloc_entry[i];
                slot_word[i][free_idx[i]] <= alloc_word[i];
                slot_lq[i][free_idx[i]] <= ld_lq_idx[i];
            end
            wake_lq_idx[i] <= slot_lq[i][wake_idx[i]];
            wake_data[i] <= entry_data[slot_entry[i][wake_idx[i]]][slot_word[i][wake_idx[i]]];
        end
    end

endmodule

// File: hw/dcache_miss.sv
`timescale 1ns/1ps

module dcache_miss #(
    parameter int load_ports = 2,
    parameter int miss_entries = 4,
    parameter int wait_slots = 4,
    parameter int id_count = 2,
    localparam int entry_bits = $clog2(miss_entries),
    localparam int id_bits = $clog2(id_count)
) (
    input  logic clk,
    input  logic rst,
    input  logic [load_ports-1:0] ld_valid,
    input  logic [load_ports-1:0][miss_pkg::paddr_width-1:0] ld_addr,
    input  logic [load_ports-1:0][miss_pkg::lq_idx_width-1:0] ld_lq_idx,
    output logic [load_ports-1:0] ld_full,
    output logic ar_valid,
    output logic [miss_pkg::paddr_width-1:0] ar_addr,
    output logic [id_bits-1:0] ar_id,
    input  logic ar_ready,
    input  logic r_valid,
    input  logic [id_bits-1:0] r_id,
    input  miss_pkg::word_t r_data,
    input  logic r_last,
    output logic refill_valid,
    output logic [miss_pkg::paddr_width-1:0] refill_addr,
    output miss_pkg::line_t refill_data,
    input  logic refill_ready,
    output logic [load_ports-1:0] wake_valid,
    output logic [load_ports-1:0][miss_pkg::lq_idx_width-1:0] wake_lq_idx,
    output miss_pkg::word_t [load_ports-1:0] wake_data
);

    logic [load_ports-1:0] slot_free;
    logic [miss_entries-1:0] entry_waiting;
    logic [load_ports-1:0] alloc_valid;
    logic [load_ports-1:0][entry_bits-1:0] alloc_entry;
    logic [load_ports-1:0][miss_pkg::word_sel_width-1:0] alloc_word;
    logic [miss_entries-1:0] fetch_pending;
    miss_pkg::line_addr_t [miss_entries-1:0] entry_addr;
    logic [miss_entries-1:0] line_ready;
    miss_pkg::line_t [miss_entries-1:0] entry_data;
    logic fetch_issue;
    logic [entry_bits-1:0] fetch_entry;
    logic line_done;
    logic [entry_bits-1:0] done_entry;
    miss_pkg::line_t done_line;

    miss_table #(
        .load_ports(load_ports),
        .miss_entries(miss_entries)
    ) u_table (
        .clk(clk),
        .rst(rst),
        .ld_valid(ld_valid),
        .ld_addr(ld_addr),
        .slot_free(slot_free),
        .entry_waiting(entry_waiting),
        .fetch_issue(fetch_issue),
        .fetch_entry(fetch_entry),
        .line_done(line_done),
        .done_entry(done_entry),
        .done_line(done_line),
        .refill_ready(refill_ready),
        .ld_full(ld_full),
        .alloc_valid(alloc_valid),
        .alloc_entry(alloc_entry),
        .alloc_word(alloc_word),
        .fetch_pending(fetch_pending),
        .entry_addr(entry_addr),
        .line_ready(line_ready),
        .entry_data(entry_data),
        .refill_valid(refill_valid),
        .refill_addr(refill_addr),
        .refill_data(refill_data)
    );

    miss_fetch #(
        .miss_entries(miss_entries),
        .id_count(id_count)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .fetch_pending(fetch_pending),
        .entry_addr(entry_addr),
        .ar_ready(ar_ready),
        .r_valid(r_valid),
        .r_id(r_id),
        .r_data(r_data),
        .r_last(r_last),
        .ar_valid(ar_valid),
        .ar_addr(ar_addr),
        .ar_id(ar_id),
        .fetch_issue(fetch_issue),
        .fetch_entry(fetch_entry),
        .line_done(line_done),
        .done_entry(done_entry),
        .done_line(done_line)
    );

    miss_wakeup #(
        .load_ports(load_ports),
        .miss_entries(miss_entries),
        .wait_slots(wait_slots)
    ) u_wakeup (
        .clk(clk),
        .rst(rst),
        .alloc_valid(alloc_valid),
        .alloc_entry(alloc_entry),
        .alloc_word(alloc_word),
        .ld_lq_idx(ld_lq_idx),
        .line_ready(line_ready),
        .entry_data(entry_data),
        .slot_free(slot_free),
        .entry_waiting(entry_waiting),
        .wake_valid(wake_valid),
        .wake_lq_idx(wake_lq_idx),
        .wake_data(wake_data)
    );

endmodule

// File: tb/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int id_count = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic interleave,
    input  logic ar_valid,
    input  logic [31:0] ar_addr,
    input  logic [$clog2(id_count)-1:0] ar_id,
    output logic ar_ready,
    output logic r_valid,
    output logic [$clog2(id_count)-1:0] r_id,
    output logic [63:0] r_data,
    output logic r_last
);

    logic [id_count-1:0] busy;
    logic [31:0] base [id_count];
    logic [1:0] beat [id_count];
    logic [1:0] delay [id_count];
    logic lock_valid;
    int last_id;

    // memory word as a fixed function of its word address
    function automatic logic [63:0] word_at(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:3], 3'b000};
        return {a ^ 32'h5a5a0f0f, ~a};
    endfunction

    assign ar_ready = !stall;

    always_ff @(posedge clk or negedge rst) begin : respond
        logic found;
        int sel;
        int k;
        if (!rst) begin
            busy <= '0;
            r_valid <= 1'b0;
            r_last <= 1'b0;
            lock_valid <= 1'b0;
            last_id <= 0;
        end else begin
            r_valid <= 1'b0;
            r_last <= 1'b0;
            found = 1'b0;
            sel = 0;
            for (int i = 0; i < id_count; i++) begin
                if (busy[i] && delay[i] != 0) begin
                    delay[i] <= delay[i] - 1'b1;
                end
            end
            // interleave mode rotates between ready ids every beat
            if (!interleave && lock_valid && busy[last_id] && delay[last_id] == 0) begin
                found = 1'b1;
                sel = last_id;
            end else begin
                for (int i = 1; i <= id_count; i++) begin
                    k = (last_id + i) % id_count;
                    if (!found && busy[k] && delay[k] == 0) begin
                        found = 1'b1;
                        sel = k;
                    end
                end
            end
            if (found) begin
                r_valid <= 1'b1;
                r_id <= sel[$clog2(id_count)-1:0];
                r_data <= word_at(base[sel] + {27'd0, beat[sel], 3'b000});
                r_last <= (beat[sel] == 2'd3);
                beat[sel] <= beat[sel] + 1'b1;
                last_id <= sel;
                lock_valid <= (beat[sel] != 2'd3);
                if (beat[sel] == 2'd3) begin
                    busy[sel] <= 1'b0;
                end
            end
            if (ar_valid && ar_ready) begin
                busy[ar_id] <= 1'b1;
                base[ar_id] <= ar_addr;
                beat[ar_id] <= 2'd0;
                delay[ar_id] <= 2'd2;
            end
        end
    end

endmodule

// File: tb/tb_dcache_miss.sv
`timescale 1ns/1ps

module tb_dcache_miss;

    logic clk;
    logic rst;
    logic [1:0] ld_valid;
    logic [1:0][31:0] ld_addr;
    logic [1:0][4:0] ld_lq_idx;
    logic [1:0] ld_full;
    logic ar_valid;
    logic [31:0] ar_addr;
    logic ar_id;
    logic ar_ready;
    logic r_valid;
    logic r_id;
    logic [63:0] r_data;
    logic r_last;
    logic refill_valid;
    logic [31:0] refill_addr;
    miss_pkg::line_t refill_data;
    logic refill_ready;
    logic [1:0] wake_valid;
    logic [1:0][4:0] wake_lq_idx;
    miss_pkg::word_t [1:0] wake_data;
    logic stall;
    logic interleave;

    int errors = 0;
    int checks = 0;
    int ar_count = 0;
    int refill_count = 0;
    int wake_count = 0;
    int outstanding = 0;
    logic [31:0] last_ar_addr;
    logic [31:0] rng;
    logic [31:0] refill_rng;
    logic rand_refill;
    bit exp_valid [2][32];
    logic [63:0] exp_word [2][32];

    dcache_miss #(
        .load_ports(2),
        .miss_entries(4),
        .wait_slots(4),
        .id_count(2)
    ) u_dut (
        .clk(clk), .rst(rst),
        .ld_valid(ld_valid), .ld_addr(ld_addr), .ld_lq_idx(ld_lq_idx), .ld_full(ld_full),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_id(ar_id), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_id(r_id), .r_data(r_data), .r_last(r_last),
        .refill_valid(refill_valid), .refill_addr(refill_addr), .refill_data(refill_data),
        .refill_ready(refill_ready),
        .wake_valid(wake_valid), .wake_lq_idx(wake_lq_idx), .wake_data(wake_data)
    );

    tb_mem_model #(.id_count(2)) u_mem (
        .clk(clk), .rst(rst), .stall(stall), .interleave(interleave),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_id(ar_id), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_id(r_id), .r_data(r_data), .r_last(r_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [63:0] expect_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:3], 3'b000};
        return {a ^ 32'h5a5a0f0f, ~a};
    endfunction

    function automatic int free_lq(input int p);
        for (int i = 0; i < 32; i++) begin
            if (!exp_valid[p][i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] rand_line();
        rng = xorshift(rng);
        return {rng[31:5], 5'b00000};
    endfunction

    // bus, refill and wake-up monitors
    always @(posedge clk) begin
        if (rst && ar_valid && ar_ready) begin
            ar_count++;
            last_ar_addr = ar_addr;
            check(ar_addr[4:0], 0, "request address alignment");
        end
        if (rst && refill_valid && refill_ready) begin
            refill_count++;
            for (int w = 0; w < 4; w++) begin
                check(refill_data[w], expect_word(refill_addr + w * 8), "refill word");
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (rst && wake_valid[p]) begin
                wake_count++;
                if (!exp_valid[p][wake_lq_idx[p]]) begin
                    report_error($sformatf("port %0d woke load %0d that was not waiting",
                                           p, wake_lq_idx[p]));
                end else begin
                    check(wake_data[p], exp_word[p][wake_lq_idx[p]], "wake-up word");
                    exp_valid[p][wake_lq_idx[p]] = 0;
                    outstanding--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rand_refill) begin
            refill_rng = xorshift(refill_rng);
            refill_ready <= refill_rng[0];
        end
    end

    // one request strobe with full sampled one cycle later
    task automatic issue_loads(input logic [1:0] mask, input logic [31:0] a0,
                               input logic [31:0] a1, output logic [1:0] full);
        logic [31:0] addr [2];
        int lq [2];
        addr[0] = a0;
        addr[1] = a1;
        lq[0] = free_lq(0);
        lq[1] = free_lq(1);
        @(posedge clk);
        ld_valid <= mask;
        ld_addr[0] <= a0;
        ld_addr[1] <= a1;
        ld_lq_idx[0] <= 5'(lq[0]);
        ld_lq_idx[1] <= 5'(lq[1]);
        @(posedge clk);
        ld_valid <= 2'b00;
        @(negedge clk);
        full = ld_full;
        for (int p = 0; p < 2; p++) begin
            if (mask[p] && !full[p]) begin
                exp_valid[p][lq[p]] = 1;
                exp_word[p][lq[p]] = expect_word(addr[p]);
                outstanding++;
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((outstanding != 0 || refill_valid) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (n >= limit) begin
            report_error("timeout waiting for wake-ups and refills to drain");
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic single_miss();
        logic [31:0] a;
        logic [1:0] f;
        int ar0, rf0, wk0;
        ar0 = ar_count;
        rf0 = refill_count;
        wk0 = wake_count;
        a = rand_line();
        issue_loads(2'b01, a | 32'h10, 32'h0, f);
        check(f, 0, "single miss full");
        wait_drain(200);
        check(ar_count - ar0, 1, "single miss requests");
        check(last_ar_addr, a, "single miss request address");
        check(refill_count - rf0, 1, "single miss refills");
        check(wake_count - wk0, 1, "single miss wake-ups");
    endtask

    task automatic merge_loads();
        logic [31:0] a;
        logic [1:0] f;
        int ar0, wk0;
        ar0 = ar_count;
        wk0 = wake_count;
        a = rand_line();
        issue_loads(2'b11, a | 32'h08, a | 32'h18, f);
        check(f, 0, "merge pair full");
        repeat (2) @(negedge clk);
        issue_loads(2'b01, a, 32'h0, f);
        check(f, 0, "merge late full");
        wait_drain(200);
        check(ar_count - ar0, 1, "merge requests");
        check(wake_count - wk0, 3, "merge wake-ups");
    endtask

    task automatic table_full();
        logic [31:0] a;
        logic [1:0] f;
        int ar0;
        ar0 = ar_count;
        a = rand_line();
        @(posedge clk);
        stall <= 1'b1;
        issue_loads(2'b11, a, a + 32'h20, f);
        check(f, 0, "first pair full");
        issue_loads(2'b11, a + 32'h40, a + 32'h60, f);
        check(f, 0, "second pair full");
        issue_loads(2'b01, a + 32'h80, 32'h0, f);
        check(f, 2'b01, "new line with table full");
        issue_loads(2'b10, 32'h0, a + 32'h28, f);
        check(f, 0, "load to pending line");
        check(ar_valid, 1, "request held during stall");
        check(ar_addr, a, "held request address");
        check(ar_id, 0, "held request id");
        @(posedge clk);
        stall <= 1'b0;
        wait_drain(400);
        check(ar_count - ar0, 4, "requests after stall");
    endtask

    task automatic interleaved_bursts();
        logic [31:0] a;
        logic [1:0] f;
        int rf0, wk0;
        rf0 = refill_count;
        wk0 = wake_count;
        a = rand_line();
        @(posedge clk);
        interleave <= 1'b1;
        issue_loads(2'b11, a | 32'h08, (a + 32'h20) | 32'h10, f);
        check(f, 0, "interleave full");
        wait_drain(300);
        check(refill_count - rf0, 2, "interleave refills");
        check(wake_count - wk0, 2, "interleave wake-ups");
        @(posedge clk);
        interleave <= 1'b0;
    endtask

    task automatic refill_backpressure();
        logic [31:0] a;
        logic [1:0] f;
        logic [31:0] held_addr;
        miss_pkg::line_t held_data;
        int n;
        int ar0, wk0;
        ar0 = ar_count;
        wk0 = wake_count;
        a = rand_line();
        @(posedge clk);
        refill_ready <= 1'b0;
        issue_loads(2'b01, a | 32'h18, 32'h0, f);
        n = 0;
        while ((wake_count == wk0 || !refill_valid) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (n >= 200) begin
            report_error("timeout waiting for wake-up under refill back-pressure");
        end
        held_addr = refill_addr;
        held_data = refill_data;
        check(held_addr, a, "held refill address");
        repeat (5) begin
            @(negedge clk);
            check(refill_valid, 1, "refill valid held");
            check(refill_addr, held_addr, "refill address stable");
            for (int w = 0; w < 4; w++) begin
                check(refill_data[w], held_data[w], "refill data stable");
            end
        end
        @(posedge clk);
        refill_ready <= 1'b1;
        wait_drain(200);
        issue_loads(2'b10, 32'h0, a, f);
        check(f, 0, "refetch full");
        wait_drain(200);
        check(ar_count - ar0, 2, "refetch requests");
    endtask

    task automatic retry_load(input int p, input logic [31:0] a);
        logic [1:0] m;
        logic [1:0] f;
        int tries;
        m = 2'b00;
        m[p] = 1'b1;
        f = m;
        tries = 0;
        while (f[p] && tries < 100) begin
            issue_loads(m, a, a, f);
            tries++;
        end
        if (f[p]) begin
            report_error($sformatf("retry on port %0d never accepted", p));
        end
    endtask

    task automatic random_loads();
        logic [31:0] pool [6];
        logic [31:0] a0, a1;
        logic [1:0] m;
        logic [1:0] f;
        pool[0] = rand_line();
        for (int k = 1; k < 6; k++) begin
            pool[k] = pool[0] + k * 32;
        end
        rand_refill = 1'b1;
        interleave <= 1'b1;
        for (int it = 0; it < 40; it++) begin
            rng = xorshift(rng);
            m = rng[1:0];
            if (m == 2'b00) begin
                m = 2'b01;
            end
            a0 = pool[rng[4:2] % 6] | {27'd0, rng[6:5], 3'b000};
            a1 = pool[rng[9:7] % 6] | {27'd0, rng[11:10], 3'b000};
            issue_loads(m, a0, a1, f);
            if (m[0] && f[0]) begin
                retry_load(0, a0);
            end
            if (m[1] && f[1]) begin
                retry_load(1, a1);
            end
        end
        rand_refill = 1'b0;
        @(posedge clk);
        refill_ready <= 1'b1;
        interleave <= 1'b0;
        wait_drain(600);
        check(outstanding, 0, "loads left waiting");
    endtask

    initial begin
        rst = 1'b0;
        ld_valid = '0;
        ld_addr = '0;
        ld_lq_idx = '0;
        refill_ready = 1'b1;
        stall = 1'b0;
        interleave = 1'b0;
        rand_refill = 1'b0;
        rng = 32'hcfb4ef61;
        refill_rng = xorshift(32'hcfb4ef61);
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check(ar_valid, 0, "ar_valid after reset");
        check(refill_valid, 0, "refill_valid after reset");
        check(wake_valid, 0, "wake_valid after reset");
        check(ld_full, 0, "ld_full after reset");
        single_miss();
        merge_loads();
        table_full();
        interleaved_bursts();
        refill_backpressure();
        random_loads();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/miss_pkg.sv
hw/miss_table.sv
hw/miss_fetch.sv
hw/miss_wakeup.sv
hw/dcache_miss.sv
tb/tb_mem_model.sv
tb/tb_dcache_miss.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_dcache_miss
FILELIST  := all.f
OBJDIR    := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
